// ==== build.f ====
source/motion_pkg.sv
source/level_map_pkg.sv
source/pace_counter.sv
source/player_motion.sv
source/terrain_contact.sv
source/switch_latches.sv
source/lift_mover.sv
source/obj_state_ctrl.sv
verification/obj_state_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module obj_state_ctrl_tb \
    > compile.log 2>&1 || { cat compile.log; exit 1; }
./obj_dir/Vobj_state_ctrl_tb > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1

// ==== source/level_map_pkg.sv ====
`default_nettype none

package level_map_pkg;
    import motion_pkg::*;

    // sprite offsets, screen position = offset +/- displacement
    localparam coord_t FOOT_Y       = 10'd230;
    localparam coord_t HEAD_Y       = 10'd199;
    localparam coord_t REACH_Y      = 10'd200; // top of the raised hand
    localparam coord_t BODY_LEFT_X  = 10'd10;
    localparam coord_t BODY_RIGHT_X = 10'd28;
    localparam coord_t SOLE_LEFT_X  = 10'd8;
    localparam coord_t SOLE_MID_X   = 10'd13;
    localparam coord_t SOLE_RIGHT_X = 10'd22;
    localparam coord_t SOLE_END_X   = 10'd25;
    localparam coord_t P2_REACH_X   = 10'd30; // player 2 sprite is wider

    localparam coord_t FLOOR_Y      = 10'd230;
    localparam coord_t FLOOR_X_END  = 10'd276;
    localparam coord_t SCREEN_X_END = 10'd320;
    localparam coord_t H_LIMIT      = 10'd282;
    localparam coord_t LEDGE_BAND   = 10'd2;

    // wall 7, the low step at the right
    localparam coord_t WALL7_X       = 10'd275;
    localparam coord_t WALL7_TOP_Y   = 10'd210;
    localparam coord_t WALL7_SIDE_Y  = 10'd220;
    localparam coord_t WALL7_STEP_X  = 10'd274;
    localparam coord_t WALL7_LEDGE_X = 10'd277;

    localparam coord_t PLAT1_Y       = 10'd182;
    localparam coord_t PLAT1_X_END   = 10'd255;
    localparam coord_t PLAT1_LEDGE_X = 10'd230;
    localparam coord_t PLAT2_Y       = 10'd139; // wall 2
    localparam coord_t PLAT2_X_START = 10'd80;
    localparam coord_t PLAT2_X_END   = 10'd310;
    localparam coord_t PLAT2_LEDGE_X = 10'd90;
    localparam coord_t PLAT3_Y       = 10'd96;  // wall 3
    localparam coord_t PLAT3_X_START = 10'd85;
    localparam coord_t PLAT3_X_END   = 10'd270;

    // undersides hit by the head while rising
    localparam coord_t CEIL1_Y       = 10'd190;
    localparam coord_t CEIL1_X_END   = 10'd240;
    localparam coord_t CEIL2_Y       = 10'd147;
    localparam coord_t CEIL2_X_START = 10'd90;
    localparam coord_t CEIL3_Y       = 10'd104;
    localparam coord_t CEIL3_X_START = 10'd75;
    localparam coord_t CEIL3_X_END   = 10'd270;

    localparam coord_t LIFT_X_END    = 10'd40;
    localparam coord_t LIFT_SIDE_Y   = 10'd165;
    localparam coord_t LIFT_BASE_Y   = 10'd139;
    localparam coord_t LIFT_LAND_Y   = 10'd161;
    localparam coord_t LIFT_LEDGE_X  = 10'd35;
    localparam coord_t LIFT_H_LIMIT  = 10'd25;
    localparam coord_t LIFT_TRAVEL   = 10'd22;

    // gate opened by button 2
    localparam coord_t GATE_X        = 10'd295;
    localparam coord_t GATE_SIDE_Y   = 10'd130;
    localparam coord_t GATE_TOP_Y    = 10'd124;

    localparam coord_t BTN1_X_LO     = 10'd100;
    localparam coord_t BTN1_X_HI     = 10'd105;
    localparam coord_t BTN1_Y_LO     = 10'd180;
    localparam coord_t BTN1_Y_HI     = 10'd182;
    localparam coord_t BTN2_X_LO     = 10'd244;
    localparam coord_t BTN2_X_HI     = 10'd250;
    localparam coord_t BTN2_Y_LO     = 10'd104;
    localparam coord_t BTN2_Y_HI     = 10'd106;

    localparam coord_t DIAMOND_X     = 10'd197;
    localparam coord_t DIAMOND_V_MAX = 10'd3;

endpackage

`default_nettype wire

// ==== source/lift_mover.sv ====
`timescale 1ns/100ps
`default_nettype none

module lift_mover
    import motion_pkg::*, level_map_pkg::*;
#(
    parameter pace_t STEP = V_STEP_CYCLES
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   button1_touch,
    input  coord_t p1_h,
    input  coord_t p1_v,
    output logic   p1_on_lift
);

    coord_t lift_rise;
    logic   lift_step;

    pace_counter #(
        .CYCLES(STEP)
    ) u_lift_pace (
        .clk      (clk),
        .reset    (reset),
        .run_level(button1_touch),
        .step     (lift_step)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            lift_rise <= '0;
        end else if (lift_step && lift_rise < LIFT_TRAVEL) begin
            lift_rise <= lift_rise + 1'b1;
        end
    end

    assign p1_on_lift = (p1_h < LIFT_H_LIMIT) && (FOOT_Y - p1_v == LIFT_BASE_Y + lift_rise);

endmodule

`default_nettype wire

// ==== source/motion_pkg.sv ====
`default_nettype none

package motion_pkg;

    // displacement in pixels from the player's start point
    typedef logic [9:0] coord_t;

    // divider count for one pixel move
    typedef logic [24:0] pace_t;

    // codes outside these four leave the player idle
    typedef enum logic [3:0] {
        MOVE_STAND = 4'd6,
        MOVE_RIGHT = 4'd7,
        MOVE_LEFT  = 4'd8,
        MOVE_UP    = 4'd9
    } move_state_t;

    typedef enum logic [1:0] {
        JUMP_NONE = 2'd0,
        JUMP_RISE = 2'd1,
        JUMP_FALL = 2'd2
    } jump_phase_t;

    localparam pace_t H_STEP_CYCLES = 25'd1_500_000; // walk pace on hardware
    localparam pace_t V_STEP_CYCLES = 25'd2_000_000; // jump and lift pace

endpackage

`default_nettype wire

// ==== source/obj_state_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module obj_state_ctrl
    import motion_pkg::*;
#(
    parameter pace_t H_STEP = H_STEP_CYCLES,
    parameter pace_t V_STEP = V_STEP_CYCLES
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        run,
    input  move_state_t p1_state,
    input  move_state_t p2_state,
    input  jump_phase_t p1_jump,
    input  jump_phase_t p2_jump,
    output coord_t      p1_h,
    output coord_t      p1_v,
    output coord_t      p2_h,
    output coord_t      p2_v,
    output logic        p1_collision,
    output logic        p2_collision,
    output logic        p1_land,
    output logic        p2_land,
    output logic        p1_should_fall,
    output logic        p2_should_fall,
    output logic        button1_touch,
    output logic        diamond_touch,
    output logic        p1_on_lift
);

    logic clear;
    logic button2_touch;

    assign clear = reset || !run; // pause also restarts the level

    player_motion #(.H_STEP(H_STEP), .V_STEP(V_STEP)) u_p1_motion (
        .clk(clk), .reset(clear), .state(p1_state), .jump(p1_jump),
        .collision(p1_collision), .h(p1_h), .v(p1_v)
    );

    player_motion #(.H_STEP(H_STEP), .V_STEP(V_STEP)) u_p2_motion (
        .clk(clk), .reset(clear), .state(p2_state), .jump(p2_jump),
        .collision(p2_collision), .h(p2_h), .v(p2_v)
    );

    terrain_contact u_p1_contact (
        .state(p1_state), .jump(p1_jump), .h(p1_h), .v(p1_v),
        .button1_touch(button1_touch), .button2_touch(button2_touch),
        .collision(p1_collision), .land(p1_land), .should_fall(p1_should_fall)
    );

    terrain_contact u_p2_contact (
        .state(p2_state), .jump(p2_jump), .h(p2_h), .v(p2_v),
        .button1_touch(button1_touch), .button2_touch(button2_touch),
        .collision(p2_collision), .land(p2_land), .should_fall(p2_should_fall)
    );

    switch_latches u_switches (
        .clk(clk), .reset(clear), .p1_state(p1_state),
        .p1_h(p1_h), .p1_v(p1_v), .p2_h(p2_h), .p2_v(p2_v),
        .button1_touch(button1_touch), .button2_touch(button2_touch),
        .diamond_touch(diamond_touch)
    );

    lift_mover #(.STEP(V_STEP)) u_lift (
        .clk(clk), .reset(clear), .button1_touch(button1_touch),
        .p1_h(p1_h), .p1_v(p1_v), .p1_on_lift(p1_on_lift)
    );

endmodule

`default_nettype wire

// ==== source/pace_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module pace_counter #(
    parameter int unsigned CYCLES = 1
) (
    input  logic clk,
    input  logic reset,
    input  logic run_level,
    output logic step
);

    localparam int CNT_W = $clog2(CYCLES + 2); // at least one bit

    logic [CNT_W-1:0] count;
    logic             at_end;

    assign at_end = (count == CNT_W'(CYCLES));
    assign step   = run_level && at_end;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (!run_level) begin
            count <= '0;
        end else if (at_end) begin
            count <= '0; // wrap on the step cycle
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/player_motion.sv ====
`timescale 1ns/100ps
`default_nettype none

module player_motion
    import motion_pkg::*, level_map_pkg::*;
#(
    parameter pace_t H_STEP = H_STEP_CYCLES,
    parameter pace_t V_STEP = V_STEP_CYCLES
) (
    input  logic        clk,
    input  logic        reset,
    input  move_state_t state,
    input  jump_phase_t jump,
    input  logic        collision,
    output coord_t      h,
    output coord_t      v
);

    logic h_run;
    logic v_run;
    logic h_step;
    logic v_step;

    assign h_run = (state == MOVE_RIGHT) || (state == MOVE_LEFT);
    assign v_run = ((jump == JUMP_RISE) || (jump == JUMP_FALL)) &&
                   ((state == MOVE_UP) || (state == MOVE_RIGHT) || (state == MOVE_LEFT));

    pace_counter #(
        .CYCLES(H_STEP)
    ) u_h_pace (
        .clk      (clk),
        .reset    (reset),
        .run_level(h_run),
        .step     (h_step)
    );

    pace_counter #(
        .CYCLES(V_STEP)
    ) u_v_pace (
        .clk      (clk),
        .reset    (reset),
        .run_level(v_run),
        .step     (v_step)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            h <= '0;
        end else if (h_step && !collision) begin
            if (state == MOVE_RIGHT && h <= H_LIMIT) begin
                h <= h + 1'b1;
            end else if (state == MOVE_LEFT && h != '0) begin
                h <= h - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            v <= '0;
        end else if (v_step) begin
            if (jump == JUMP_RISE) begin
                v <= v + 1'b1;
            end else if (jump == JUMP_FALL && v != '0) begin
                v <= v - 1'b1; // floor stops the fall
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/switch_latches.sv ====
`timescale 1ns/100ps
`default_nettype none

module switch_latches
    import motion_pkg::*, level_map_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  move_state_t p1_state,
    input  coord_t      p1_h,
    input  coord_t      p1_v,
    input  coord_t      p2_h,
    input  coord_t      p2_v,
    output logic        button1_touch,
    output logic        button2_touch,
    output logic        diamond_touch
);

    logic button1_seen;
    logic button2_seen;
    logic diamond_seen;
    logic button1_held;
    logic button2_held;
    logic diamond_held;

    // sprite span [lx, rx] overlapping a button window
    function automatic logic in_window(input coord_t lx, input coord_t rx, input coord_t y,
                                       input coord_t x_lo, input coord_t x_hi,
                                       input coord_t y_lo, input coord_t y_hi);
        in_window = rx >= x_lo && lx < x_hi && y >= y_lo && y <= y_hi;
    endfunction

    assign button1_seen =
        in_window(SOLE_LEFT_X + p1_h, SOLE_RIGHT_X + p1_h, FOOT_Y - p1_v,
                  BTN1_X_LO, BTN1_X_HI, BTN1_Y_LO, BTN1_Y_HI) ||
        in_window(BODY_LEFT_X + p2_h, P2_REACH_X + p2_h, FOOT_Y - p2_v,
                  BTN1_X_LO, BTN1_X_HI, BTN1_Y_LO, BTN1_Y_HI);

    // button 2 hangs overhead, hit with the hand
    assign button2_seen =
        in_window(SOLE_LEFT_X + p1_h, SOLE_RIGHT_X + p1_h, REACH_Y - p1_v,
                  BTN2_X_LO, BTN2_X_HI, BTN2_Y_LO, BTN2_Y_HI) ||
        in_window(BODY_LEFT_X + p2_h, P2_REACH_X + p2_h, REACH_Y - p2_v,
                  BTN2_X_LO, BTN2_X_HI, BTN2_Y_LO, BTN2_Y_HI);

    assign diamond_seen = (SOLE_RIGHT_X + p1_h == DIAMOND_X) && (p1_state == MOVE_RIGHT) &&
                          (p1_v < DIAMOND_V_MAX);

    always_ff @(posedge clk) begin
        if (reset) begin
            button1_held <= 1'b0;
            button2_held <= 1'b0;
            diamond_held <= 1'b0;
        end else begin
            button1_held <= button1_held || button1_seen;
            button2_held <= button2_held || button2_seen;
            diamond_held <= diamond_held || diamond_seen;
        end
    end

    assign button1_touch = button1_seen || button1_held;
    assign button2_touch = button2_seen || button2_held;
    assign diamond_touch = diamond_seen || diamond_held;

endmodule

`default_nettype wire

// ==== source/terrain_contact.sv ====
`timescale 1ns/100ps
`default_nettype none

module terrain_contact
    import motion_pkg::*, level_map_pkg::*;
(
    input  move_state_t state,
    input  jump_phase_t jump,
    input  coord_t      h,
    input  coord_t      v,
    input  logic        button1_touch,
    input  logic        button2_touch,
    output logic        collision,
    output logic        land,
    output logic        should_fall
);

    coord_t left_x;
    coord_t right_x;
    coord_t sole_l;
    coord_t sole_m;
    coord_t sole_r;
    coord_t sole_end;
    coord_t foot_y;
    coord_t head_y;
    logic   rising;
    logic   falling;
    logic   go_right;
    logic   go_left;
    logic [6:0] hit;
    logic [6:0] touch_down;
    logic [4:0] off_edge;

    assign left_x   = BODY_LEFT_X + h;
    assign right_x  = BODY_RIGHT_X + h;
    assign sole_l   = SOLE_LEFT_X + h;
    assign sole_m   = SOLE_MID_X + h;
    assign sole_r   = SOLE_RIGHT_X + h;
    assign sole_end = SOLE_END_X + h;
    assign foot_y   = FOOT_Y - v;
    assign head_y   = HEAD_Y - v;

    assign rising   = (jump == JUMP_RISE);
    assign falling  = (jump == JUMP_FALL);
    assign go_right = (state == MOVE_RIGHT);
    assign go_left  = (state == MOVE_LEFT);

    // blocking rules
    assign hit[0] = rising && head_y == CEIL1_Y && left_x < CEIL1_X_END;
    assign hit[1] = go_right && right_x >= WALL7_X && foot_y >= WALL7_SIDE_Y;
    assign hit[2] = rising && head_y == CEIL2_Y && left_x >= CEIL2_X_START;
    assign hit[3] = button1_touch && go_left && left_x <= LIFT_X_END &&
                    foot_y <= PLAT1_Y && foot_y >= LIFT_SIDE_Y;   // raised lift side
    assign hit[4] = !button1_touch && left_x < LIFT_X_END &&
                    head_y <= CEIL2_Y && head_y >= LIFT_BASE_Y;   // lift still down
    assign hit[5] = rising && head_y == CEIL3_Y &&
                    left_x >= CEIL3_X_START && left_x < CEIL3_X_END;
    assign hit[6] = go_right && button2_touch && right_x >= GATE_X &&
                    foot_y >= GATE_SIDE_Y;

    // landing rules, only while falling
    assign touch_down[0] = foot_y == FLOOR_Y && right_x < FLOOR_X_END;
    assign touch_down[1] = sole_m >= WALL7_STEP_X && right_x <= SCREEN_X_END &&
                           foot_y == WALL7_TOP_Y;
    assign touch_down[2] = foot_y == PLAT1_Y && sole_end < PLAT1_X_END;
    assign touch_down[3] = button1_touch && foot_y == LIFT_LAND_Y && sole_l <= LIFT_X_END;
    assign touch_down[4] = sole_m >= PLAT2_X_START && sole_m < PLAT2_X_END &&
                           foot_y == PLAT2_Y;
    assign touch_down[5] = button2_touch && foot_y == GATE_TOP_Y && sole_l >= GATE_X;
    assign touch_down[6] = sole_m >= PLAT3_X_START && sole_m < PLAT3_X_END &&
                           foot_y == PLAT3_Y;

    // walked past a ledge
    assign off_edge[0] = go_left && sole_r <= WALL7_LEDGE_X &&
                         foot_y >= WALL7_TOP_Y && foot_y < WALL7_TOP_Y + LEDGE_BAND;
    assign off_edge[1] = go_right && sole_l >= PLAT1_LEDGE_X &&
                         foot_y >= PLAT1_Y && foot_y < PLAT1_Y + LEDGE_BAND;
    assign off_edge[2] = go_right && sole_l >= LIFT_LEDGE_X &&
                         foot_y >= LIFT_LAND_Y && foot_y < LIFT_LAND_Y + LEDGE_BAND;
    assign off_edge[3] = go_left && sole_r <= PLAT2_LEDGE_X &&
                         foot_y >= PLAT2_Y - LEDGE_BAND && foot_y <= PLAT2_Y;
    assign off_edge[4] = go_left && sole_r <= GATE_X &&
                         foot_y >= GATE_TOP_Y - LEDGE_BAND && foot_y <= GATE_TOP_Y;

    assign collision   = |hit;
    assign land        = falling && (|touch_down);
    assign should_fall = |off_edge;

endmodule

`default_nettype wire

// ==== verification/obj_state_ctrl_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module obj_state_ctrl_tb
    import motion_pkg::*;
();

    localparam int MAX_CYCLES = 20000; // script runs about 2700 cycles

    logic        clk = 1'b0;
    logic        reset;
    logic        run;
    move_state_t p1_state;
    move_state_t p2_state;
    jump_phase_t p1_jump;
    jump_phase_t p2_jump;
    coord_t      p1_h;
    coord_t      p1_v;
    coord_t      p2_h;
    coord_t      p2_v;
    logic        p1_collision;
    logic        p2_collision;
    logic        p1_land;
    logic        p2_land;
    logic        p1_should_fall;
    logic        p2_should_fall;
    logic        button1_touch;
    logic        diamond_touch;
    logic        p1_on_lift;

    logic         active;
    logic         p1_walking;
    logic         p1_rising;
    logic         p1_falling;
    logic [4:0]   walk_hist = '0;
    logic [4:0]   rise_hist = '0;
    logic [4:0]   fall_hist = '0;
    coord_t [4:0] h_hist = '0; // [0] is the last sample
    coord_t [4:0] v_hist = '0;
    coord_t       p2_h_prev = '0;
    logic         clear_prev = 1'b0;
    logic         stand_prev = 1'b0;
    logic         p1_coll_prev = 1'b0;
    logic         p2_coll_prev = 1'b0;
    logic         button1_prev = 1'b0;
    logic         diamond_prev = 1'b0;
    logic [31:0]  lfsr_state = 32'h21cb6389;
    int           cycle_count = 0;

    initial begin
        forever #4 clk = ~clk;
    end

    obj_state_ctrl #(
        .H_STEP(3),
        .V_STEP(4)
    ) u_dut (
        .clk           (clk),
        .reset         (reset),
        .run           (run),
        .p1_state      (p1_state),
        .p2_state      (p2_state),
        .p1_jump       (p1_jump),
        .p2_jump       (p2_jump),
        .p1_h          (p1_h),
        .p1_v          (p1_v),
        .p2_h          (p2_h),
        .p2_v          (p2_v),
        .p1_collision  (p1_collision),
        .p2_collision  (p2_collision),
        .p1_land       (p1_land),
        .p2_land       (p2_land),
        .p1_should_fall(p1_should_fall),
        .p2_should_fall(p2_should_fall),
        .button1_touch (button1_touch),
        .diamond_touch (diamond_touch),
        .p1_on_lift    (p1_on_lift)
    );

    assign active     = run && !reset;
    assign p1_walking = active && p1_state == MOVE_RIGHT && p1_jump == JUMP_NONE &&
                        !p1_collision && p1_h < 10'd282;
    assign p1_rising  = active && p1_state == MOVE_UP && p1_jump == JUMP_RISE;
    assign p1_falling = active && p1_state == MOVE_UP && p1_jump == JUMP_FALL;

    always @(posedge clk) begin
        walk_hist    <= {walk_hist[3:0], p1_walking};
        rise_hist    <= {rise_hist[3:0], p1_rising};
        fall_hist    <= {fall_hist[3:0], p1_falling};
        h_hist       <= {h_hist[3:0], p1_h};
        v_hist       <= {v_hist[3:0], p1_v};
        p2_h_prev    <= p2_h;
        clear_prev   <= !active;
        stand_prev   <= active && p1_state == MOVE_STAND;
        p1_coll_prev <= active && p1_collision;
        p2_coll_prev <= active && p2_collision;
        button1_prev <= active && button1_touch;
        diamond_prev <= active && diamond_touch;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            stop_with_error("timeout: the test script did not finish in the cycle budget");
        end
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    // galois form, taps 32,22,2,1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        next_lfsr = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic random_bits(input int unsigned count, output int unsigned value);
        int unsigned i;
        value = 0;
        for (i = 0; i < count; i++) begin
            value = (value << 1) | lfsr_state[0];
            lfsr_state = next_lfsr(lfsr_state);
        end
    endtask

    task automatic drive_players(input move_state_t s1, input jump_phase_t j1,
                                 input move_state_t s2, input jump_phase_t j2);
        p1_state <= s1;
        p1_jump  <= j1;
        p2_state <= s2;
        p2_jump  <= j2;
    endtask

    task automatic hold_stand();
        int unsigned hold;
        random_bits(4, hold);
        drive_players(MOVE_STAND, JUMP_NONE, MOVE_STAND, JUMP_NONE);
        repeat (hold + 2) @(posedge clk);
    endtask

    clear_pos_chk: assert property (@(posedge clk) clear_prev |->
        p1_h == '0 && p1_v == '0 && p2_h == '0 && p2_v == '0)
        else stop_with_error($sformatf(
            "[FAIL] after clear p1_h=%h p1_v=%h p2_h=%h p2_v=%h, expected 0",
            $sampled(p1_h), $sampled(p1_v), $sampled(p2_h), $sampled(p2_v)));

    clear_flag_chk: assert property (@(posedge clk) clear_prev |->
        !button1_touch && !diamond_touch && !p1_on_lift)
        else stop_with_error($sformatf(
            "[FAIL] after clear button1_touch=%h diamond_touch=%h p1_on_lift=%h",
            $sampled(button1_touch), $sampled(diamond_touch), $sampled(p1_on_lift)));

    stand_chk: assert property (@(posedge clk) stand_prev |-> p1_h == h_hist[0])
        else stop_with_error($sformatf("[FAIL] p1_h moved while standing, expected %h got %h",
            $sampled(h_hist[0]), $sampled(p1_h)));

    // one pixel per 4 cycles of walking
    pace_chk: assert property (@(posedge clk) walk_hist[3:0] == 4'hf |-> p1_h == h_hist[3] + 10'd1)
        else stop_with_error($sformatf("[FAIL] p1_h expected %h got %h",
            $sampled(h_hist[3]) + 10'd1, $sampled(p1_h)));

    p1_wall_chk: assert property (@(posedge clk)
        active && p1_state == MOVE_RIGHT && p1_v == '0 && p1_h <= 10'd247 |->
        p1_collision == (p1_h == 10'd247))
        else stop_with_error($sformatf("[FAIL] p1_collision got %h at p1_h %h",
            $sampled(p1_collision), $sampled(p1_h)));

    p2_wall_chk: assert property (@(posedge clk)
        active && p2_state == MOVE_RIGHT && p2_v == '0 && p2_h <= 10'd247 |->
        p2_collision == (p2_h == 10'd247))
        else stop_with_error($sformatf("[FAIL] p2_collision got %h at p2_h %h",
            $sampled(p2_collision), $sampled(p2_h)));

    p1_block_chk: assert property (@(posedge clk) p1_coll_prev |-> p1_h <= h_hist[0])
        else stop_with_error($sformatf("[FAIL] p1_h rose under collision from %h to %h",
            $sampled(h_hist[0]), $sampled(p1_h)));

    p2_block_chk: assert property (@(posedge clk) p2_coll_prev |-> p2_h <= p2_h_prev)
        else stop_with_error($sformatf("[FAIL] p2_h rose under collision from %h to %h",
            $sampled(p2_h_prev), $sampled(p2_h)));

    rise_chk: assert property (@(posedge clk) rise_hist == 5'h1f |-> p1_v == v_hist[4] + 10'd1)
        else stop_with_error($sformatf("[FAIL] p1_v expected %h got %h",
            $sampled(v_hist[4]) + 10'd1, $sampled(p1_v)));

    fall_chk: assert property (@(posedge clk) fall_hist == 5'h1f |->
        p1_v == ((v_hist[4] == '0) ? 10'd0 : v_hist[4] - 10'd1))
        else stop_with_error($sformatf("[FAIL] p1_v falling from %h got %h",
            $sampled(v_hist[4]), $sampled(p1_v)));

    land_chk: assert property (@(posedge clk)
        active && p1_jump == JUMP_FALL && p1_v == '0 && p1_h < 10'd248 |-> p1_land)
        else stop_with_error($sformatf("[FAIL] p1_land expected 1 got %h at p1_h %h",
            $sampled(p1_land), $sampled(p1_h)));

    p2_land_chk: assert property (@(posedge clk)
        active && p2_jump == JUMP_FALL && p2_v == '0 && p2_h < 10'd248 |-> p2_land)
        else stop_with_error($sformatf("[FAIL] p2_land expected 1 got %h at p2_h %h",
            $sampled(p2_land), $sampled(p2_h)));

    // no ledge to walk off on the floor
    p1_ledge_chk: assert property (@(posedge clk) active && p1_v == '0 |-> !p1_should_fall)
        else stop_with_error($sformatf("[FAIL] p1_should_fall expected 0 got %h at p1_h %h",
            $sampled(p1_should_fall), $sampled(p1_h)));

    p2_ledge_chk: assert property (@(posedge clk) active && p2_v == '0 |-> !p2_should_fall)
        else stop_with_error($sformatf("[FAIL] p2_should_fall expected 0 got %h at p2_h %h",
            $sampled(p2_should_fall), $sampled(p2_h)));

    button1_chk: assert property (@(posedge clk)
        active && p1_v == 10'd49 && p1_h == 10'd80 |-> button1_touch)
        else stop_with_error("[FAIL] button1_touch expected 1 got 0 at p1_h 050 p1_v 031");

    button1_hold_chk: assert property (@(posedge clk) button1_prev |-> button1_touch)
        else stop_with_error("[FAIL] button1_touch expected 1 got 0 after latching");

    lift_chk: assert property (@(posedge clk) active && button1_touch && p1_on_lift |->
        p1_h < 10'd15)
        else stop_with_error($sformatf("[FAIL] p1_on_lift high with p1_h %h", $sampled(p1_h)));

    // feet level with the fully raised lift
    lift_ride_chk: assert property (@(posedge clk)
        active && button1_touch && p1_h < 10'd15 && p1_v == 10'd69 |-> p1_on_lift)
        else stop_with_error($sformatf("[FAIL] p1_on_lift expected 1 got %h at p1_v %h",
            $sampled(p1_on_lift), $sampled(p1_v)));

    diamond_chk: assert property (@(posedge clk)
        active && p1_state == MOVE_RIGHT && p1_v < 10'd3 && p1_h == 10'd175 |-> diamond_touch)
        else stop_with_error("[FAIL] diamond_touch expected 1 got 0 at p1_h 0af");

    diamond_hold_chk: assert property (@(posedge clk) diamond_prev |-> diamond_touch)
        else stop_with_error("[FAIL] diamond_touch expected 1 got 0 after latching");

    initial begin
        reset <= 1'b1;
        run   <= 1'b1;
        drive_players(MOVE_STAND, JUMP_NONE, MOVE_STAND, JUMP_NONE);
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        hold_stand();

        // p1 passes the diamond on the way to the step wall
        drive_players(MOVE_RIGHT, JUMP_NONE, MOVE_RIGHT, JUMP_NONE);
        while (p1_h != 10'd247 || p2_h != 10'd247) @(posedge clk);
        repeat (20) @(posedge clk); // keep pushing
        drive_players(MOVE_LEFT, JUMP_NONE, MOVE_LEFT, JUMP_NONE);
        repeat (24) @(posedge clk);
        hold_stand();

        run <= 1'b0; // level restart
        repeat (2) @(posedge clk);
        run <= 1'b1;
        hold_stand();

        drive_players(MOVE_UP, JUMP_RISE, MOVE_STAND, JUMP_NONE);
        while (p1_v != 10'd49) @(posedge clk);
        hold_stand();
        drive_players(MOVE_RIGHT, JUMP_NONE, MOVE_STAND, JUMP_NONE);
        while (p1_h != 10'd80) @(posedge clk);
        hold_stand();
        drive_players(MOVE_UP, JUMP_FALL, MOVE_UP, JUMP_FALL);
        while (p1_v != 10'd0) @(posedge clk);
        repeat (12) @(posedge clk); // resting on the floor
        hold_stand();
        drive_players(MOVE_LEFT, JUMP_NONE, MOVE_STAND, JUMP_NONE);
        while (p1_h != 10'd5) @(posedge clk);
        hold_stand();
        drive_players(MOVE_UP, JUMP_RISE, MOVE_STAND, JUMP_NONE);
        while (p1_v != 10'd69) @(posedge clk); // up onto the raised lift
        hold_stand();

        reset <= 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        hold_stand();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
